//--- source/pwr_pkg.sv
/* Power domain package
   Status codes of the switchable domain and default timing constants */
package pwr_pkg;

  // ----------------------------------------------------------
  // Domain status
  // ----------------------------------------------------------
  localparam int STATUS_W = 2;

  typedef enum logic [STATUS_W-1:0] {
    // Powered, clock running, outputs released
    STATUS_ON         = 2'd0,
    // Switch open, domain held in reset and isolated
    STATUS_OFF        = 2'd1,
    // Power-down sequence running
    STATUS_GOING_DOWN = 2'd2,
    // Power-up sequence running
    STATUS_GOING_UP   = 2'd3
  } pwr_status_e;

  // ----------------------------------------------------------
  // Default timing, in clock cycles
  // ----------------------------------------------------------

  // Switch command to acknowledge
  localparam int DEF_SWITCH_ACK_LATENCY = 15;

  // Reset kept asserted after the switch reports power good
  localparam int DEF_RST_HOLD_CYCLES = 8;

endpackage

//--- source/domain_ctrl_if.sv
/* Domain control bundle
   Active-low switch, isolation, reset and clock-gate levels with the switch acknowledge */
interface domain_ctrl_if;

  logic switch_n;
  logic switch_ack_n;
  logic iso_n;
  logic dom_rst_n;
  // Low lets the domain clock run
  logic clkgate_en_n;

  // Sequencer side
  modport seq (
    output switch_n,
    output iso_n,
    output dom_rst_n,
    output clkgate_en_n,
    input  switch_ack_n
  );

  // Power switch side
  modport sw (
    input  switch_n,
    output switch_ack_n
  );

  // Observation at the top level
  modport mon (
    input switch_n,
    input switch_ack_n,
    input iso_n,
    input dom_rst_n,
    input clkgate_en_n
  );

endinterface

//--- source/pwr_seq_fsm.sv
/* Power sequencer for one switchable domain
   Steps the control levels down and up and keeps a sticky done interrupt */
module pwr_seq_fsm (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 off_req_i,
  input  logic                 on_req_i,
  input  logic                 irq_clr_i,
  domain_ctrl_if.seq           ctrl,
  output logic                 hold_start_o,
  input  logic                 hold_done_i,
  output pwr_pkg::pwr_status_e status_o,
  output logic                 busy_o,
  output logic                 done_irq_o
);

  // Each state names the step taken when it is left
  typedef enum logic [3:0] {
    S_ON      = 4'd0,
    S_DN_ISO  = 4'd1,
    S_DN_RST  = 4'd2,
    S_DN_SW   = 4'd3,
    S_DN_ACK  = 4'd4,
    S_OFF     = 4'd5,
    S_UP_ACK  = 4'd6,
    S_UP_HOLD = 4'd7,
    S_UP_ISO  = 4'd8,
    S_UP_CLK  = 4'd9
  } state_e;

  state_e state_q;
  logic   switch_n_q;
  logic   iso_n_q;
  logic   dom_rst_n_q;
  logic   clkgate_en_n_q;
  logic   hold_start_q;
  logic   done_irq_q;
  logic   done_set;

  // ----------------------------------------------------------
  // Sequencing
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q        <= S_ON;
      switch_n_q     <= 1'b0;
      iso_n_q        <= 1'b1;
      dom_rst_n_q    <= 1'b1;
      clkgate_en_n_q <= 1'b0;
      hold_start_q   <= 1'b0;
    end else begin
      hold_start_q <= 1'b0;
      case (state_q)
        S_ON: begin
          if (off_req_i) begin
            clkgate_en_n_q <= 1'b1;
            state_q        <= S_DN_ISO;
          end
        end
        S_DN_ISO: begin
          iso_n_q <= 1'b0;
          state_q <= S_DN_RST;
        end
        S_DN_RST: begin
          dom_rst_n_q <= 1'b0;
          state_q     <= S_DN_SW;
        end
        S_DN_SW: begin
          switch_n_q <= 1'b1;
          state_q    <= S_DN_ACK;
        end
        S_DN_ACK: begin
          if (ctrl.switch_ack_n) begin
            state_q <= S_OFF;
          end
        end
        S_OFF: begin
          if (on_req_i) begin
            switch_n_q <= 1'b0;
            state_q    <= S_UP_ACK;
          end
        end
        S_UP_ACK: begin
          // Power good, start the reset hold
          if (!ctrl.switch_ack_n) begin
            hold_start_q <= 1'b1;
            state_q      <= S_UP_HOLD;
          end
        end
        S_UP_HOLD: begin
          if (hold_done_i) begin
            dom_rst_n_q <= 1'b1;
            state_q     <= S_UP_ISO;
          end
        end
        S_UP_ISO: begin
          iso_n_q <= 1'b1;
          state_q <= S_UP_CLK;
        end
        S_UP_CLK: begin
          clkgate_en_n_q <= 1'b0;
          state_q        <= S_ON;
        end
        default: state_q <= S_ON;
      endcase
    end
  end

  assign ctrl.switch_n     = switch_n_q;
  assign ctrl.iso_n        = iso_n_q;
  assign ctrl.dom_rst_n    = dom_rst_n_q;
  assign ctrl.clkgate_en_n = clkgate_en_n_q;
  assign hold_start_o      = hold_start_q;

  // ----------------------------------------------------------
  // Status and done interrupt
  // ----------------------------------------------------------
  assign done_set = ((state_q == S_DN_ACK) && ctrl.switch_ack_n) || (state_q == S_UP_CLK);

  // Completion beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_irq_q <= 1'b0;
    end else if (done_set) begin
      done_irq_q <= 1'b1;
    end else if (irq_clr_i) begin
      done_irq_q <= 1'b0;
    end
  end

  assign done_irq_o = done_irq_q;

  always_comb begin
    case (state_q)
      S_ON:                                  status_o = pwr_pkg::STATUS_ON;
      S_OFF:                                 status_o = pwr_pkg::STATUS_OFF;
      S_DN_ISO, S_DN_RST, S_DN_SW, S_DN_ACK: status_o = pwr_pkg::STATUS_GOING_DOWN;
      default:                               status_o = pwr_pkg::STATUS_GOING_UP;
    endcase
  end

  assign busy_o = (status_o == pwr_pkg::STATUS_GOING_DOWN) ||
                  (status_o == pwr_pkg::STATUS_GOING_UP);

  // Domain must be isolated and in reset whenever the switch is open
  a_off_isolated : assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl.switch_n |-> (!ctrl.iso_n && !ctrl.dom_rst_n));

  // Timer expiry only expected while waiting for it
  a_hold_done_state : assert property (@(posedge clk_i) disable iff (rst_i)
    hold_done_i |-> (state_q == S_UP_HOLD));

endmodule

//--- source/settle_timer.sv
/* Reset hold timer
   Pulses done once, RST_HOLD_CYCLES cycles after the last start */
module settle_timer #(
  parameter int RST_HOLD_CYCLES = pwr_pkg::DEF_RST_HOLD_CYCLES
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  output logic done_o
);

  localparam int CNT_W = (RST_HOLD_CYCLES > 1) ? $clog2(RST_HOLD_CYCLES) : 1;
  localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(RST_HOLD_CYCLES - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             running_q;

  // A start while running reloads the count
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end else if (start_i) begin
      running_q <= 1'b1;
      cnt_q     <= LOAD_VAL;
    end else if (running_q) begin
      if (cnt_q == '0) begin
        running_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign done_o = running_q && (cnt_q == '0);

  a_done_single : assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |=> !done_o);

endmodule

//--- source/switch_ack_line.sv
/* Power switch model
   Returns the switch command as its acknowledge after a fixed delay */
module switch_ack_line #(
  parameter int SWITCH_ACK_LATENCY = pwr_pkg::DEF_SWITCH_ACK_LATENCY
) (
  input logic       clk_i,
  input logic       rst_i,
  domain_ctrl_if.sw sw
);

  logic [SWITCH_ACK_LATENCY-1:0] stage_q;

  // Reset leaves every stage at the switch-on level
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= sw.switch_n;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign sw.switch_ack_n = stage_q[SWITCH_ACK_LATENCY-1];

  // Checked once the whole line holds post-reset history
  a_ack_delay : assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i, SWITCH_ACK_LATENCY) |->
      (sw.switch_ack_n == $past(sw.switch_n, SWITCH_ACK_LATENCY)));

endmodule

//--- source/pwr_domain_top.sv
/* Power domain controller top
   Sequencer, reset hold timer and switch model behind plain ports */
module pwr_domain_top #(
  parameter int SWITCH_ACK_LATENCY = pwr_pkg::DEF_SWITCH_ACK_LATENCY,
  parameter int RST_HOLD_CYCLES    = pwr_pkg::DEF_RST_HOLD_CYCLES
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         off_req_i,
  input  logic                         on_req_i,
  input  logic                         irq_clr_i,
  output logic [pwr_pkg::STATUS_W-1:0] status_o,
  output logic                         busy_o,
  output logic                         done_irq_o,
  output logic                         pwr_switch_n_o,
  output logic                         switch_ack_n_o,
  output logic                         iso_n_o,
  output logic                         dom_rst_n_o,
  output logic                         clkgate_en_n_o
);

  domain_ctrl_if u_ctrl_if ();

  pwr_pkg::pwr_status_e status;
  logic                 hold_start;
  logic                 hold_done;

  pwr_seq_fsm u_seq (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .off_req_i    (off_req_i),
    .on_req_i     (on_req_i),
    .irq_clr_i    (irq_clr_i),
    .ctrl         (u_ctrl_if.seq),
    .hold_start_o (hold_start),
    .hold_done_i  (hold_done),
    .status_o     (status),
    .busy_o       (busy_o),
    .done_irq_o   (done_irq_o)
  );

  settle_timer #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
  ) u_hold_timer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (hold_start),
    .done_o  (hold_done)
  );

  switch_ack_line #(
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) u_switch (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .sw    (u_ctrl_if.sw)
  );

  // Monitor view of the control bundle
  assign status_o       = status;
  assign pwr_switch_n_o = u_ctrl_if.switch_n;
  assign switch_ack_n_o = u_ctrl_if.switch_ack_n;
  assign iso_n_o        = u_ctrl_if.iso_n;
  assign dom_rst_n_o    = u_ctrl_if.dom_rst_n;
  assign clkgate_en_n_o = u_ctrl_if.clkgate_en_n;

endmodule

//--- testbench/tb_pwr_domain.sv
/* Power domain controller testbench
   Replays the golden command list and checks step timing, status and interrupt */
module tb_pwr_domain;

  localparam int LAT      = pwr_pkg::DEF_SWITCH_ACK_LATENCY;
  localparam int HOLD     = pwr_pkg::DEF_RST_HOLD_CYCLES;
  localparam int MAX_CMDS = 64;
  // Bit positions in ctl_now
  localparam int C_ACK = 0, C_SW = 1, C_RST = 2, C_ISO = 3, C_CLK = 4;

  logic clk_i, rst_i, off_req_i, on_req_i, irq_clr_i;
  logic [pwr_pkg::STATUS_W-1:0] status_o;
  logic busy_o, done_irq_o;
  logic pwr_switch_n_o, switch_ack_n_o, iso_n_o, dom_rst_n_o, clkgate_en_n_o;

  logic [11:0] golden_mem [MAX_CMDS];
  int unsigned rng;
  int cyc, n_cmds, value_errs, other_errs;
  int cycle_limit = 0;
  // Cycle of the last change on each control output
  int t_chg [5];
  logic [4:0] ctl_prev;
  wire [4:0] ctl_now = {clkgate_en_n_o, iso_n_o, dom_rst_n_o, pwr_switch_n_o, switch_ack_n_o};

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  pwr_domain_top u_dut (.*);

  function automatic int unsigned xorshift32(input int unsigned x);
    int unsigned y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_val(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      value_errs++;
    end
  endtask

  // One clock, outputs sampled at the falling edge
  task automatic step_cycle();
    @(negedge clk_i);
    cyc++;
    for (int b = 0; b < 5; b++) begin
      if (ctl_now[b] != ctl_prev[b]) begin
        t_chg[b] = cyc;
      end
    end
    ctl_prev = ctl_now;
    assert (busy_o == (status_o == pwr_pkg::STATUS_GOING_DOWN ||
                       status_o == pwr_pkg::STATUS_GOING_UP)) else begin
      $display("busy_o disagrees with status_o at cycle %0d", cyc);
      other_errs++;
    end
  endtask

  task automatic pulse_req(input logic off, input logic on, input logic clr);
    off_req_i = off;
    on_req_i  = on;
    irq_clr_i = clr;
    step_cycle();
    off_req_i = 1'b0;
    on_req_i  = 1'b0;
    irq_clr_i = 1'b0;
  endtask

  task automatic run_transition(input bit down);
    int    c0;
    int    k;
    int    stray_at;
    int    exp_going;
    string busy_name;
    c0 = cyc;
    rng = xorshift32(rng);
    // About half the transitions see a stray request while busy
    stray_at = rng[0] ? int'(rng[4:1]) + 2 : 0;
    exp_going = down ? pwr_pkg::STATUS_GOING_DOWN : pwr_pkg::STATUS_GOING_UP;
    busy_name = down ? "pd status while busy" : "pu status while busy";
    pulse_req(down, !down, 1'b0);
    k = 1;
    while (busy_o) begin
      check_val(busy_name, exp_going, status_o);
      if (k == stray_at) begin
        off_req_i = rng[5];
        on_req_i  = !rng[5];
      end
      step_cycle();
      off_req_i = 1'b0;
      on_req_i  = 1'b0;
      k++;
    end
    if (down) begin
      check_val("pd clkgate_en_n rise cycle", c0 + 1, t_chg[C_CLK]);
      check_val("pd iso_n fall cycle", c0 + 2, t_chg[C_ISO]);
      check_val("pd dom_rst_n fall cycle", c0 + 3, t_chg[C_RST]);
      check_val("pd switch_n rise cycle", c0 + 4, t_chg[C_SW]);
      check_val("pd switch_ack_n rise cycle", t_chg[C_SW] + LAT, t_chg[C_ACK]);
      check_val("pd completion cycle", t_chg[C_ACK] + 1, cyc);
      check_val("pd final levels", 5'b10011, ctl_now);
    end else begin
      check_val("pu switch_n fall cycle", c0 + 1, t_chg[C_SW]);
      check_val("pu switch_ack_n fall cycle", t_chg[C_SW] + LAT, t_chg[C_ACK]);
      assert (t_chg[C_RST] - t_chg[C_ACK] >= HOLD) else begin
        $display("Domain reset released too early after power good at cycle %0d", cyc);
        other_errs++;
      end
      check_val("pu iso_n rise cycle", t_chg[C_RST] + 1, t_chg[C_ISO]);
      check_val("pu clkgate_en_n fall cycle", t_chg[C_ISO] + 1, t_chg[C_CLK]);
      check_val("pu final levels", 5'b01100, ctl_now);
    end
  endtask

  initial begin
    logic [3:0]                   cmd;
    logic                         accept;
    logic [pwr_pkg::STATUS_W-1:0] exp_status;
    rng        = 86931;
    cyc        = 0;
    value_errs = 0;
    other_errs = 0;
    rst_i      = 1'b1;
    off_req_i  = 1'b0;
    on_req_i   = 1'b0;
    irq_clr_i  = 1'b0;
    $readmemh("testbench/pwr_golden.txt", golden_mem);
    n_cmds = 0;
    while (n_cmds < MAX_CMDS && golden_mem[n_cmds][11:8] != 4'hf) begin
      n_cmds++;
    end
    if (n_cmds == MAX_CMDS) begin
      $display("Golden file has no end marker, no commands run");
      other_errs++;
      n_cmds = 0;
    end
    cycle_limit = 32 + n_cmds * (2 * LAT + HOLD + 40);
    repeat (16) @(negedge clk_i);
    rst_i    = 1'b0;
    ctl_prev = ctl_now;
    check_val("reset status", pwr_pkg::STATUS_ON, status_o);
    check_val("reset busy", 0, busy_o);
    check_val("reset done_irq", 0, done_irq_o);
    check_val("reset control levels", 5'b01100, ctl_now);
    exp_status = pwr_pkg::STATUS_ON;

    for (int i = 0; i < n_cmds; i++) begin
      cmd = golden_mem[i][11:8];
      rng = xorshift32(rng);
      repeat (rng % 8) step_cycle();
      if (cmd == 4'h0) begin
        repeat ((rng >> 8) % 16 + 1) step_cycle();
      end else if (cmd == 4'h3) begin
        pulse_req(1'b0, 1'b0, 1'b1);
      end else begin
        // Requests count only in the matching stable state
        accept = (cmd == 4'h1) ? (exp_status == pwr_pkg::STATUS_ON)
                               : (exp_status == pwr_pkg::STATUS_OFF);
        if (accept) begin
          run_transition(cmd == 4'h1);
        end else begin
          pulse_req(cmd == 4'h1, cmd == 4'h2, 1'b0);
          check_val($sformatf("entry %0d ignored request busy", i + 1), 0, busy_o);
        end
      end
      check_val($sformatf("entry %0d status", i + 1), golden_mem[i][7:4], status_o);
      check_val($sformatf("entry %0d done_irq", i + 1), golden_mem[i][3:0], done_irq_o);
      exp_status = golden_mem[i][4 +: pwr_pkg::STATUS_W];
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk_i);
    $display("Timeout after %0d cycles, command list did not complete", cycle_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- testbench/pwr_golden.txt
// Columns, one hex digit each: command, expected status, expected done interrupt
// Commands: 0 idle, 1 off request, 2 on request, 3 interrupt clear, f end of list
000
200 // on while on
111
111 // off while off
310
010
110
201
201 // on while on
300
111
201 // irq left set across both transitions
001
300
300
111
310
201
111
201
300
000
f00

//--- list.f
source/pwr_pkg.sv
source/domain_ctrl_if.sv
source/pwr_seq_fsm.sv
source/settle_timer.sv
source/switch_ack_line.sv
source/pwr_domain_top.sv
testbench/tb_pwr_domain.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the power domain testbench
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pwr_domain -f list.f -o tb_pwr_domain

./obj_dir/tb_pwr_domain | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
